/* src/tile_pkg.sv */
`default_nettype none

package tile_pkg;

	// Track geometry, four sides with four tracks each
	localparam int NUM_SIDES = 4;
	localparam int NUM_TRACKS = 4;
	localparam int TILE_TRACKS = NUM_SIDES * NUM_TRACKS;

	localparam int CFG_W = 32;

	// PE opcodes, anything else decodes as LUT
	localparam logic [2:0] OP_LUT = 3'd0;
	localparam logic [2:0] OP_ADD = 3'd1;
	localparam logic [2:0] OP_SUB = 3'd2;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One configuration word, read as switch selects or as PE fields
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef union packed {
		// Select for outbound track 4*side+track sits at bits 2*idx+1:2*idx
		logic [TILE_TRACKS-1:0][1:0] sel;
		struct packed {
			logic [CFG_W-16:0] rsvd;
			logic [3:0] lut; // Truth table indexed by {a,b}
			logic [3:0] sel_b;
			logic [3:0] sel_a;
			logic [2:0] opcode;
		} pe;
	} tile_cfg_u;

endpackage

`default_nettype wire

/* src/run_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module run_timer #(
	parameter int CYCLE_W = 16
) (
	input wire clk,
	input wire reset,
	input wire load_i,
	input wire [CYCLE_W-1:0] cycles_i,
	output logic last_o
);

	logic [CYCLE_W-1:0] count_q;

	// Counts down to zero and then rests there
	always_ff @(posedge clk) begin
		if (reset) begin
			count_q <= '0;
		end else if (load_i) begin
			count_q <= cycles_i;
		end else if (count_q != '0) begin
			count_q <= count_q - 1'b1;
		end
	end

	// High during the final enabled cycle of a run
	assign last_o = (count_q == {{(CYCLE_W-1){1'b0}}, 1'b1});

endmodule

`default_nettype wire

/* src/tile_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tile_ctrl #(
	parameter int CYCLE_W = 16
) (
	input wire clk,
	input wire reset,
	input wire cfg_we_i,
	input wire start_i,
	input wire [CYCLE_W-1:0] cycles_i,
	input wire last_i,
	output logic sb_cfg_we_o,
	output logic pe_cfg_we_o,
	output logic timer_load_o,
	output logic run_en_o,
	output logic busy_o,
	output logic done_o
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_WAIT_PE = 2'd1;
	localparam logic [1:0] ST_READY = 2'd2;
	localparam logic [1:0] ST_RUN = 2'd3;

	logic [1:0] state_q;
	logic [1:0] state_nxt;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write steering and start acceptance
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign sb_cfg_we_o = cfg_we_i && (state_q == ST_IDLE || state_q == ST_READY);
	assign pe_cfg_we_o = cfg_we_i && (state_q == ST_WAIT_PE);

	// A write in the same cycle takes priority over the start
	assign timer_load_o = start_i && !cfg_we_i && (state_q == ST_READY)
		&& (cycles_i != '0);

	assign run_en_o = (state_q == ST_RUN);
	assign busy_o = (state_q == ST_RUN);

	always_comb begin
		state_nxt = state_q;
		case (state_q)
			ST_IDLE: if (cfg_we_i) state_nxt = ST_WAIT_PE;
			ST_WAIT_PE: if (cfg_we_i) state_nxt = ST_READY;
			ST_READY: begin
				if (cfg_we_i) begin
					state_nxt = ST_WAIT_PE; // Reconfiguration restarts the pair
				end else if (timer_load_o) begin
					state_nxt = ST_RUN;
				end
			end
			default: if (last_i) state_nxt = ST_READY;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= ST_IDLE;
			done_o <= 1'b0;
		end else begin
			state_q <= state_nxt;
			done_o <= (state_q == ST_RUN) && last_i;
		end
	end

endmodule

`default_nettype wire

/* src/switch_box.sv */
`timescale 1ns/1ps
`default_nettype none

module switch_box (
	input wire clk,
	input wire reset,
	input wire cfg_we_i,
	input tile_pkg::tile_cfg_u cfg_data_i,
	input wire [tile_pkg::TILE_TRACKS-1:0] in_tracks_i,
	input wire pe_out_i,
	output logic [tile_pkg::TILE_TRACKS-1:0] out_tracks_o
);

	tile_pkg::tile_cfg_u cfg_q;

	// Routing configuration, all selects start at 0
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg_q <= '0;
		end else if (cfg_we_i) begin
			cfg_q <= cfg_data_i;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Track multiplexers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Select k of 0..2 takes side (s+1+k) mod 4, and the track index is shifted
	// by that source side so neighbouring sides do not all land on one track

	for (genvar s = 0; s < tile_pkg::NUM_SIDES; s++) begin : g_side
		for (genvar t = 0; t < tile_pkg::NUM_TRACKS; t++) begin : g_track
			localparam int OUT_IDX = s * tile_pkg::NUM_TRACKS + t;

			localparam int SIDE_0 = (s + 1) % tile_pkg::NUM_SIDES;
			localparam int SIDE_1 = (s + 2) % tile_pkg::NUM_SIDES;
			localparam int SIDE_2 = (s + 3) % tile_pkg::NUM_SIDES;

			localparam int SRC_0 = SIDE_0 * tile_pkg::NUM_TRACKS
				+ (t + SIDE_0 + 3) % tile_pkg::NUM_TRACKS;
			localparam int SRC_1 = SIDE_1 * tile_pkg::NUM_TRACKS
				+ (t + SIDE_1 + 3) % tile_pkg::NUM_TRACKS;
			localparam int SRC_2 = SIDE_2 * tile_pkg::NUM_TRACKS
				+ (t + SIDE_2 + 3) % tile_pkg::NUM_TRACKS;

			logic [3:0] cand;

			// Select 3 feeds the PE result back into the fabric
			assign cand = {pe_out_i, in_tracks_i[SRC_2], in_tracks_i[SRC_1],
				in_tracks_i[SRC_0]};

			assign out_tracks_o[OUT_IDX] = cand[cfg_q.sel[OUT_IDX]];
		end
	end

endmodule

`default_nettype wire

/* src/bit_pe.sv */
`timescale 1ns/1ps
`default_nettype none

module bit_pe (
	input wire clk,
	input wire reset,
	input wire cfg_we_i,
	input tile_pkg::tile_cfg_u cfg_data_i,
	input wire start_i,
	input wire run_en_i,
	input wire [tile_pkg::TILE_TRACKS-1:0] in_tracks_i,
	output logic pe_out_o
);

	tile_pkg::tile_cfg_u cfg_q;

	logic op_a;
	logic op_b;
	logic is_arith;
	logic is_sub;
	logic carry_q;
	logic sum;
	logic carry_nxt;

	// Cleared config decodes as LUT with an all-zero table
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg_q <= '0;
		end else if (cfg_we_i) begin
			cfg_q <= cfg_data_i;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Operand pick and serial arithmetic
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign op_a = in_tracks_i[cfg_q.pe.sel_a];
	assign is_sub = (cfg_q.pe.opcode == tile_pkg::OP_SUB);
	assign is_arith = (cfg_q.pe.opcode == tile_pkg::OP_ADD) || is_sub;
	assign op_b = in_tracks_i[cfg_q.pe.sel_b] ^ is_sub; // Subtract adds the complement

	assign sum = op_a ^ op_b ^ carry_q;
	assign carry_nxt = (op_a & op_b) | (op_a & carry_q) | (op_b & carry_q);

	always_ff @(posedge clk) begin
		if (reset) begin
			carry_q <= 1'b0;
			pe_out_o <= 1'b0;
		end else if (start_i) begin
			carry_q <= is_sub; // Borrow-in of the two's complement
		end else if (run_en_i) begin
			if (is_arith) begin
				pe_out_o <= sum;
				carry_q <= carry_nxt;
			end else begin
				pe_out_o <= cfg_q.pe.lut[{op_a, op_b}];
			end
		end
	end

endmodule

`default_nettype wire

/* src/cgra_tile.sv */
`timescale 1ns/1ps
`default_nettype none

module cgra_tile #(
	parameter int CYCLE_W = 16
) (
	input wire clk,
	input wire reset,
	input wire cfg_we_i,
	input wire [tile_pkg::CFG_W-1:0] cfg_data_i,
	input wire start_i,
	input wire [CYCLE_W-1:0] cycles_i,
	input wire [tile_pkg::TILE_TRACKS-1:0] in_tracks_i,
	output logic [tile_pkg::TILE_TRACKS-1:0] out_tracks_o,
	output logic pe_out_o,
	output logic busy_o,
	output logic done_o
);

	logic sb_cfg_we;
	logic pe_cfg_we;
	logic timer_load;
	logic run_en;
	logic last_cycle;
	logic pe_out;

	tile_ctrl #(.CYCLE_W(CYCLE_W)) u_ctrl (
		.clk(clk),
		.reset(reset),
		.cfg_we_i(cfg_we_i),
		.start_i(start_i),
		.cycles_i(cycles_i),
		.last_i(last_cycle),
		.sb_cfg_we_o(sb_cfg_we),
		.pe_cfg_we_o(pe_cfg_we),
		.timer_load_o(timer_load),
		.run_en_o(run_en),
		.busy_o(busy_o),
		.done_o(done_o)
	);

	run_timer #(.CYCLE_W(CYCLE_W)) u_timer (
		.clk(clk),
		.reset(reset),
		.load_i(timer_load),
		.cycles_i(cycles_i),
		.last_o(last_cycle)
	);

	switch_box u_sb (
		.clk(clk),
		.reset(reset),
		.cfg_we_i(sb_cfg_we),
		.cfg_data_i(cfg_data_i),
		.in_tracks_i(in_tracks_i),
		.pe_out_i(pe_out),
		.out_tracks_o(out_tracks_o)
	);

	// The accepted start doubles as the carry preset
	bit_pe u_pe (
		.clk(clk),
		.reset(reset),
		.cfg_we_i(pe_cfg_we),
		.cfg_data_i(cfg_data_i),
		.start_i(timer_load),
		.run_en_i(run_en),
		.in_tracks_i(in_tracks_i),
		.pe_out_o(pe_out)
	);

	assign pe_out_o = pe_out;

endmodule

`default_nettype wire

/* verif/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD_NS = 100
) (
	output logic clk_o
);

	// First rising edge lands half a period in
	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

endmodule

`default_nettype wire

/* verif/tile_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module tile_sva (
	input wire clk,
	input wire reset,
	input wire [1:0] state_i,
	input wire cfg_we_i,
	input wire last_i,
	input wire sb_cfg_we_i,
	input wire pe_cfg_we_i,
	input wire run_en_i,
	input wire busy_i,
	input wire done_i
);

	localparam logic [1:0] ST_WAIT_PE = 2'd1;
	localparam logic [1:0] ST_READY = 2'd2;

	a_done_pulse: assert property (@(posedge clk) disable iff (reset) done_i |=> !done_i)
		else $error("done stayed high for more than one cycle");

	// Done only in the cycle right after busy falls
	a_done_after_busy: assert property (@(posedge clk) disable iff (reset)
		done_i |-> (!busy_i && $past(busy_i)))
		else $error("done pulsed without a run ending");

	// Busy and run enable stay up together until the timer flags the last cycle
	a_run_holds: assert property (@(posedge clk) disable iff (reset)
		(busy_i && !last_i) |=> (busy_i && run_en_i))
		else $error("run ended before its last cycle");

	a_run_ends: assert property (@(posedge clk) disable iff (reset)
		(busy_i && last_i) |=> (!busy_i && !run_en_i && done_i))
		else $error("run did not end with a done pulse after its last cycle");

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Configuration order
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_sb_order: assert property (@(posedge clk) disable iff (reset)
		sb_cfg_we_i |=> (state_i == ST_WAIT_PE))
		else $error("switch word written out of order");

	a_pe_order: assert property (@(posedge clk) disable iff (reset)
		pe_cfg_we_i |=> (state_i == ST_READY))
		else $error("PE word written before the switch word");

	a_no_run_write: assert property (@(posedge clk) disable iff (reset)
		(busy_i && cfg_we_i) |=> (busy_i || done_i))
		else $error("configuration written during a run");

endmodule

`default_nettype wire

/* verif/tb_cgra_tile.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cgra_tile;

	localparam int CYCLE_W = 16;
	localparam int FIELDS = 7; // kind, switch word, PE word, cycles, a, b, expected
	localparam int MAX_RECS = 64;
	localparam int ROUTE_CHECKS = 4;
	localparam string DATA_FILE = "verif/tile_testdata.txt";

	logic clk;
	logic reset;
	logic cfg_we;
	logic [31:0] cfg_data;
	logic start;
	logic [CYCLE_W-1:0] cycles;
	logic [15:0] in_tracks;
	wire [15:0] out_tracks;
	wire pe_out;
	wire busy;
	wire done;

	logic [31:0] tdata [0:FIELDS*MAX_RECS-1];
	logic [31:0] rng_state;
	logic pe_expect; // Value the PE output should be holding
	int num_recs;
	bit watch_armed;

	tb_clkgen #(.PERIOD_NS(100)) u_clk (
		.clk_o(clk)
	);

	cgra_tile #(.CYCLE_W(CYCLE_W)) uut (
		.clk(clk),
		.reset(reset),
		.cfg_we_i(cfg_we),
		.cfg_data_i(cfg_data),
		.start_i(start),
		.cycles_i(cycles),
		.in_tracks_i(in_tracks),
		.out_tracks_o(out_tracks),
		.pe_out_o(pe_out),
		.busy_o(busy),
		.done_o(done)
	);

	bind tile_ctrl tile_sva u_sva (
		.clk(clk),
		.reset(reset),
		.state_i(state_q),
		.cfg_we_i(cfg_we_i),
		.last_i(last_i),
		.sb_cfg_we_i(sb_cfg_we_o),
		.pe_cfg_we_i(pe_cfg_we_o),
		.run_en_i(run_en_o),
		.busy_i(busy_o),
		.done_i(done_o)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference models and helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Select k picks side (s+1+k) mod 4, track (t+side+3) mod 4, and 3 picks the PE
	function automatic logic [15:0] route_model(input logic [31:0] sw, input logic [15:0] trk,
		input logic pe_bit);
		logic [15:0] res;
		int k;
		int side;
		int src;
		for (int s = 0; s < 4; s++) begin
			for (int t = 0; t < 4; t++) begin
				k = int'(sw[2*(4*s+t) +: 2]);
				side = (s + 1 + k) % 4;
				src = 4 * side + (t + side + 3) % 4;
				res[4*s+t] = (k == 3) ? pe_bit : trk[src];
			end
		end
		return res;
	endfunction

	function automatic logic [15:0] operand_pattern(input logic [15:0] noise,
		input logic [3:0] sel_a, input logic [3:0] sel_b, input logic a, input logic b);
		logic [15:0] p;
		p = noise;
		p[sel_a] = a;
		p[sel_b] = b;
		return p;
	endfunction

	task automatic next_rand(output logic [15:0] val);
		rng_state = xorshift(rng_state);
		val = rng_state[15:0];
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TB FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else
			report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic write_cfg(input logic [31:0] word);
		@(posedge clk);
		cfg_we <= 1'b1;
		cfg_data <= word;
		@(posedge clk);
		cfg_we <= 1'b0;
	endtask

	task automatic pulse_start(input int n);
		@(posedge clk);
		start <= 1'b1;
		cycles <= n[CYCLE_W-1:0];
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic expect_no_run(input int count);
		repeat (count) begin
			@(negedge clk);
			assert (!busy && !done) else
				report_failure("a start was accepted that should have been ignored");
		end
	endtask

	// Operand bit k is on the tracks for edge N+k+1 and its result shows after that edge
	task automatic run_stream(input logic [31:0] pe_word, input int n,
		input logic [31:0] a_bits, input logic [31:0] b_bits, input logic [31:0] exp_bits,
		input bit inject);
		logic [15:0] noise;
		pulse_start(n);
		for (int k = 0; k <= n; k++) begin
			if (k < n) begin
				next_rand(noise);
				in_tracks <= operand_pattern(noise, pe_word[6:3], pe_word[10:7],
					a_bits[k], b_bits[k]);
			end
			if (inject) begin
				cfg_we <= (k == 2); // Must be dropped by the controller
				cfg_data <= 32'hffff_ffff;
			end
			@(negedge clk);
			if (k > 0) check_value("pe_out_o", 32'(pe_out), 32'(exp_bits[k-1]));
			check_value("busy_o", 32'(busy), 32'(k < n));
			check_value("done_o", 32'(done), 32'(k == n));
			if (k < n) @(posedge clk);
		end
		pe_expect = exp_bits[n-1];
	endtask

	task automatic check_routing(input logic [31:0] sw_word, input int count);
		logic [15:0] pat;
		for (int i = 0; i < count; i++) begin
			next_rand(pat);
			@(posedge clk);
			in_tracks <= pat;
			@(negedge clk);
			check_value("out_tracks_o", 32'(out_tracks),
				32'(route_model(sw_word, pat, pe_expect)));
			check_value("pe_out_o", 32'(pe_out), 32'(pe_expect));
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		int base;
		reset = 1'b1;
		cfg_we = 1'b0;
		cfg_data = 32'h0;
		start = 1'b0;
		cycles = '0;
		in_tracks = 16'h0;
		rng_state = 32'd87;
		pe_expect = 1'b0;
		$readmemh(DATA_FILE, tdata);
		num_recs = 0;
		while (num_recs < MAX_RECS && tdata[num_recs*FIELDS] != 32'hff) num_recs++;
		assert (num_recs > 0) else report_failure("no test records were read from the data file");
		watch_armed = 1'b1;

		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("busy_o", 32'(busy), 32'h0);
		check_value("done_o", 32'(done), 32'h0);
		check_value("pe_out_o", 32'(pe_out), 32'h0);
		check_routing(32'h0, ROUTE_CHECKS);

		// Starts in IDLE and WAIT_PE, then a zero length start in READY
		pulse_start(5);
		expect_no_run(4);
		write_cfg(32'h0);
		pulse_start(5);
		expect_no_run(4);
		write_cfg(32'h0);
		pulse_start(0);
		expect_no_run(4);

		for (int r = 0; r < num_recs; r++) begin
			base = r * FIELDS;
			write_cfg(tdata[base+1]);
			write_cfg(tdata[base+2]);
			case (tdata[base])
				32'd0: begin
					if (tdata[base+3] != 0) begin
						run_stream(tdata[base+2], int'(tdata[base+3]), tdata[base+4],
							tdata[base+5], tdata[base+6], 1'b0);
					end
				end
				32'd1: begin
					for (int p = 0; p < 4; p++) begin
						run_stream(tdata[base+2], 1, 32'(p >> 1), 32'(p & 1),
							tdata[base+6] >> p, 1'b0);
					end
				end
				32'd2: begin
					run_stream(tdata[base+2], int'(tdata[base+3]), tdata[base+4],
						tdata[base+5], tdata[base+6], 1'b1);
				end
				default: report_failure("unknown record kind in the test data");
			endcase
			check_routing(tdata[base+1], ROUTE_CHECKS);
		end

		$display("TB PASSED");
		$finish;
	end

	initial begin : watchdog
		int limit;
		wait (watch_armed);
		limit = (num_recs + (num_recs + 1) * ROUTE_CHECKS) * 40;
		repeat (limit) @(posedge clk);
		$display("timeout after %0d clock cycles", limit);
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

/* verif/tile_testdata.txt */
// kind switch_word pe_word cycles a_bits b_bits expected (hex, bits sent LSB first)
// kind 0 run, 1 LUT sweep with expected bit 2a+b per pair, 2 run with a write inside, ff ends
0 00000000 00000000 0000 00000000 00000000 00000000
1 1B1B1B1B 00000280 0000 00000000 00000000 00000000
1 E4E4E4E4 00000B08 0000 00000000 00000000 00000001
1 12345678 00001390 0000 00000000 00000000 00000002
1 9ABCDEF0 00001C18 0000 00000000 00000000 00000003
1 55555555 000024A0 0000 00000000 00000000 00000004
1 AAAAAAAA 00002D28 0000 00000000 00000000 00000005
1 0F0F0F0F 000035B0 0000 00000000 00000000 00000006
1 F0F0F0F0 00003E38 0000 00000000 00000000 00000007
1 FFFFFFFF 000046C0 0000 00000000 00000000 00000008
1 3C3C3C3C 00004F48 0000 00000000 00000000 00000009
1 C3C3C3C3 000057D0 0000 00000000 00000000 0000000A
1 DEADBEEF 00005858 0000 00000000 00000000 0000000B
1 0123ABCD 000060E0 0000 00000000 00000000 0000000C
1 76543210 00006968 0000 00000000 00000000 0000000D
1 FEDCBA98 000071F0 0000 00000000 00000000 0000000E
1 A5A55A5A 00007A78 0000 00000000 00000000 0000000F
1 6B6B6B6B 0000490B 0000 00000000 00000000 00000009
0 C0FFEE00 00000491 0008 0000005A 0000003C 00000096
0 13579BDF 00000491 0010 0000FFFF 00000001 00000000
0 2468ACE0 00000781 000C 00000ABC 00000123 00000BDF
0 FFFF0000 00000259 0010 00001234 0000FEDC 00001110
0 0000FFFF 00000491 0005 00000013 0000000F 00000002
0 B4B4B4B4 000001F2 0008 00000064 0000001E 00000046
0 4B4B4B4B 000001F2 0008 00000010 00000020 000000F0
0 E1E1E1E1 0000043A 0010 00008000 00000001 00007FFF
0 1E1E1E1E 0000062A 000C 00000555 00000555 00000000
0 87878787 0000043A 0004 00000003 00000009 0000000A
0 78787878 00000781 0001 00000001 00000001 00000000
2 39393939 00000259 000A 000002AA 00000155 000003FF
2 C6C6C6C6 0000062A 0008 00000005 00000007 000000FE
0 FFFFFFFF 00000000 0000 00000000 00000000 00000000
0 D2D2D2D2 00000000 0000 00000000 00000000 00000000
0 3F3F3F3F 00000000 0000 00000000 00000000 00000000
ff 00000000 00000000 0000 00000000 00000000 00000000

/* sources.f */
src/tile_pkg.sv
src/run_timer.sv
src/tile_ctrl.sv
src/switch_box.sv
src/bit_pe.sv
src/cgra_tile.sv
verif/tb_clkgen.sv
verif/tile_sva.sv
verif/tb_cgra_tile.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_cgra_tile
FILELIST   := sources.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
